// File: hw/vec_issue_pkg.sv
`default_nettype none

package vec_issue_pkg;

	////////////////////////////////////////
	// Default sizing, overridden from the top
	////////////////////////////////////////
	localparam int CONVOY_DEPTH_DEF = 8;   // Entries per convoy
	localparam int SLOT_W_DEF       = 3;   // Width of a slot index
	localparam int RELEASE_GAP_DEF  = 3;   // Extra freeze cycles after exu_done

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////
	// Major opcodes of the vector instructions handled here
	typedef enum logic [6:0] {
		OP_VLOAD  = 7'b0000111,    // Unit-stride load
		OP_VSTORE = 7'b0100111,    // Unit-stride store
		OP_VARITH = 7'b1010111     // OP-V arithmetic
	} vec_opcode_e;

	typedef enum logic [1:0] {UOP_ARITH, UOP_LOAD, UOP_STORE} uop_kind_e;

	// Second ALU source, picked from funct3 for arithmetic
	typedef enum logic [1:0] {SRC_VV, SRC_VX, SRC_VI} src_sel_e;

	typedef enum logic [1:0] {S_IDLE, S_COLLECT, S_DRAIN, S_RELEASE} ctrl_state_e;

	////////////////////////////////////////
	// Records
	////////////////////////////////////////
	// One decoded vector instruction, 32 bits
	typedef struct packed {
		logic [5:0]  spare;        // Always zero, pads the record to a word
		uop_kind_e   kind;
		logic [5:0]  funct6;       // instr[31:26]
		logic        mask_en;      // Inverse of vm
		logic [4:0]  vs2;          // instr[24:20]
		logic [4:0]  vs1_rs1;      // vs1, rs1 or uimm5, by src_sel
		src_sel_e    src_sel;
		logic [4:0]  vd;           // instr[11:7]
	} vec_uop_t;

	// Item handed to the execution unit, 67 bits
	typedef struct packed {
		vec_uop_t              uop;
		logic [31:0]           rs1_value;   // Scalar operand read at dispatch
		logic [SLOT_W_DEF-1:0] slot;        // Position inside the convoy
	} vec_issue_t;

endpackage

`default_nettype wire

// File: hw/vec_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module vec_decoder (
	input  wire logic [31:0]        instr,
	output logic                    is_vector,
	output vec_issue_pkg::vec_uop_t uop
);
	import vec_issue_pkg::*;

	logic [6:0] opcode;    // Major opcode field
	logic [2:0] funct3;    // Operand form for OP-V

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	always_comb begin
		// Field slicing is common to all three vector forms
		uop         = '0;
		uop.funct6  = instr[31:26];
		uop.mask_en = ~instr[25];          // vm low means masked
		uop.vs2     = instr[24:20];
		uop.vs1_rs1 = instr[19:15];
		uop.vd      = instr[11:7];
		uop.kind    = UOP_ARITH;
		uop.src_sel = SRC_VX;              // Memory ops take the base from rs1
		is_vector   = 1'b0;

		case (opcode)
			OP_VLOAD: begin
				is_vector = 1'b1;
				uop.kind  = UOP_LOAD;
			end
			OP_VSTORE: begin
				is_vector = 1'b1;
				uop.kind  = UOP_STORE;
			end
			OP_VARITH: begin
				// Only the three listed forms belong to the vector unit
				case (funct3)
					3'b000: begin
						is_vector   = 1'b1;
						uop.src_sel = SRC_VV;    // vs1 register
					end
					3'b100: begin
						is_vector   = 1'b1;
						uop.src_sel = SRC_VX;    // Scalar rs1
					end
					3'b011: begin
						is_vector   = 1'b1;
						uop.src_sel = SRC_VI;    // uimm5 in the vs1 field
					end
					default: ;                   // Left to the scalar pipe
				endcase
			end
			default: ;                           // Scalar instruction
		endcase
	end

endmodule

`default_nettype wire

// File: hw/convoy_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module convoy_buffer #(
	parameter int CONVOY_DEPTH = vec_issue_pkg::CONVOY_DEPTH_DEF,
	parameter int SLOT_W       = vec_issue_pkg::SLOT_W_DEF
) (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    wr_en,
	input  wire vec_issue_pkg::vec_uop_t wr_uop,
	input  wire logic                    clear,
	input  wire logic [SLOT_W-1:0]       rd_slot,
	output vec_issue_pkg::vec_uop_t      rd_uop,
	output logic [SLOT_W:0]              count,
	output logic                         full
);
	import vec_issue_pkg::*;

	localparam logic [SLOT_W:0] DEPTH_C = (SLOT_W + 1)'(CONVOY_DEPTH);

	vec_uop_t mem [CONVOY_DEPTH];    // Convoy record

	////////////////////////////////////////
	// Fill count
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;                 // Flush or end of release
		end else if (wr_en) begin
			count <= count + 1'b1;
		end
	end

	// High once the record holds CONVOY_DEPTH entries,
	// including the entry landing on this edge
	assign full = (count == DEPTH_C) || (wr_en && (count == DEPTH_C - 1'b1));

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[count[SLOT_W-1:0]] <= wr_uop;    // Next free slot
		end
	end

	assign rd_uop = mem[rd_slot];    // Dispatcher read, combinational

	// Control must stop fetch before the record overflows
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (reset)
		(count == DEPTH_C) |-> !wr_en
	) else $error("convoy_buffer: write into a full record");

endmodule

`default_nettype wire

// File: hw/convoy_control.sv
`timescale 1ns/1ps
`default_nettype none

module convoy_control #(
	parameter int RELEASE_GAP = vec_issue_pkg::RELEASE_GAP_DEF
) (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic instr_valid,
	input  wire logic is_vector,
	input  wire logic branch_taken,
	input  wire logic full,
	input  wire logic drain_done,
	input  wire logic exu_done,
	output logic      instr_ready,
	output logic      wr_en,
	output logic      clear,
	output logic      drain_start,
	output logic      freeze
);
	import vec_issue_pkg::*;

	localparam int               GAP_W   = $clog2(RELEASE_GAP + 2);
	localparam logic [GAP_W-1:0] GAP_END = GAP_W'(RELEASE_GAP);

	ctrl_state_e      state;
	ctrl_state_e      state_n;
	logic             accept;     // Fetch handshake this cycle
	logic             flush;      // Branch discards the convoy
	logic             gap_run;    // exu_done seen, counting the gap
	logic             gap_end;    // Last cycle of the freeze
	logic [GAP_W-1:0] gap_cnt;

	////////////////////////////////////////
	// Handshake and strobes
	////////////////////////////////////////
	assign instr_ready = (state == S_IDLE) || (state == S_COLLECT);    // State only
	assign freeze      = (state == S_DRAIN) || (state == S_RELEASE);
	assign accept      = instr_valid && instr_ready;
	assign flush       = (state == S_COLLECT) && branch_taken;
	assign wr_en       = accept && is_vector && !flush;    // Branch wins over the write
	assign gap_end     = (state == S_RELEASE) && gap_run && (gap_cnt == GAP_END);
	assign clear       = flush || gap_end;

	////////////////////////////////////////
	// Next state
	////////////////////////////////////////
	always_comb begin
		state_n = state;
		case (state)
			S_IDLE: begin
				// Scalar instructions pass through untouched
				if (wr_en) begin
					state_n = full ? S_DRAIN : S_COLLECT;
				end
			end
			S_COLLECT: begin
				if (flush) begin
					state_n = S_IDLE;
				end else if (accept && (!is_vector || full)) begin
					state_n = S_DRAIN;     // Scalar interruption or record full
				end
			end
			S_DRAIN: begin
				if (drain_done) begin
					state_n = S_RELEASE;
				end
			end
			S_RELEASE: begin
				if (gap_end) begin
					state_n = S_IDLE;
				end
			end
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state       <= S_IDLE;
			drain_start <= 1'b0;
			gap_run     <= 1'b0;
			gap_cnt     <= '0;
		end else begin
			state       <= state_n;
			drain_start <= (state_n == S_DRAIN) && (state != S_DRAIN);    // Entry pulse
			// Gap counter starts on the first exu_done in S_RELEASE
			if ((state != S_RELEASE) || gap_end) begin
				gap_run <= 1'b0;
				gap_cnt <= '0;
			end else if (!gap_run) begin
				gap_run <= exu_done;
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end
	end

	// Freeze holds RELEASE_GAP+1 cycles past the sampled exu_done, then fetch opens
	a_release_gap: assert property (
		@(posedge clk) disable iff (reset)
		((state == S_RELEASE) && !gap_run && exu_done)
			|-> ##(RELEASE_GAP + 1) freeze ##1 (!freeze && instr_ready)
	) else $error("convoy_control: freeze not released after the gap");

endmodule

`default_nettype wire

// File: hw/vec_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module vec_dispatch #(
	parameter int SLOT_W = vec_issue_pkg::SLOT_W_DEF
) (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    drain_start,
	input  wire logic [SLOT_W:0]         count,
	input  wire vec_issue_pkg::vec_uop_t rd_uop,
	input  wire logic [31:0]             rs1_data,
	output logic [SLOT_W-1:0]            rd_slot,
	output logic [4:0]                   rs1_sel,
	input  wire logic                    exu_ready,
	output logic                         exu_valid,
	output vec_issue_pkg::vec_issue_t    exu_item,
	output logic                         drain_done
);
	import vec_issue_pkg::*;

	logic [SLOT_W:0] ptr;          // Next entry to load
	logic            xfer;         // Handshake on the execution port
	logic            more;         // Entries left behind the one on the port
	logic            load;         // Output stage takes a new entry
	vec_issue_t      next_item;

	assign rd_slot = ptr[SLOT_W-1:0];
	assign rs1_sel = rd_uop.vs1_rs1;    // Register file answers in the same cycle
	assign xfer    = exu_valid && exu_ready;
	assign more    = (ptr != count);
	assign load    = drain_start || (xfer && more);

	// Item assembled from the record and the scalar read
	always_comb begin
		next_item.uop       = rd_uop;
		next_item.rs1_value = rs1_data;
		next_item.slot      = rd_slot;
	end

	////////////////////////////////////////
	// Output stage
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exu_valid  <= 1'b0;
			ptr        <= '0;
			drain_done <= 1'b0;
		end else begin
			drain_done <= 1'b0;
			if (load) begin
				exu_valid <= 1'b1;         // Back to back when accepted
				ptr       <= ptr + 1'b1;
			end else if (xfer) begin
				exu_valid  <= 1'b0;        // Last entry gone
				ptr        <= '0;
				drain_done <= 1'b1;
			end
		end
	end

	// Payload only moves on a load, so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (load) begin
			exu_item <= next_item;
		end
	end

	a_item_hold: assert property (
		@(posedge clk) disable iff (reset)
		(exu_valid && !exu_ready) |=> (exu_valid && $stable(exu_item))
	) else $error("vec_dispatch: exu_item changed while stalled");

endmodule

`default_nettype wire

// File: hw/vec_issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module vec_issue_top #(
	parameter int CONVOY_DEPTH = vec_issue_pkg::CONVOY_DEPTH_DEF,
	parameter int SLOT_W       = vec_issue_pkg::SLOT_W_DEF,
	parameter int RELEASE_GAP  = vec_issue_pkg::RELEASE_GAP_DEF
) (
	input  wire logic                 clk,
	input  wire logic                 reset,
	// Fetch side
	input  wire logic                 instr_valid,
	input  wire logic [31:0]          instr,
	output logic                      instr_ready,
	// Scalar pipeline
	output logic                      freeze,
	input  wire logic                 branch_taken,
	output logic [4:0]                rs1_sel,
	input  wire logic [31:0]          rs1_data,
	// Execution unit
	output logic                      exu_valid,
	output vec_issue_pkg::vec_issue_t exu_item,
	input  wire logic                 exu_ready,
	input  wire logic                 exu_done
);
	import vec_issue_pkg::*;

	logic              is_vector;
	vec_uop_t          dec_uop;      // Decoder to record
	vec_uop_t          rd_uop;       // Record to dispatcher
	logic              wr_en;
	logic              clear;
	logic              drain_start;
	logic              drain_done;
	logic              full;
	logic [SLOT_W:0]   count;
	logic [SLOT_W-1:0] rd_slot;

	vec_decoder u_decoder (
		.instr     (instr),
		.is_vector (is_vector),
		.uop       (dec_uop)
	);

	convoy_buffer #(
		.CONVOY_DEPTH (CONVOY_DEPTH),
		.SLOT_W       (SLOT_W)
	) u_buffer (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (wr_en),
		.wr_uop  (dec_uop),
		.clear   (clear),
		.rd_slot (rd_slot),
		.rd_uop  (rd_uop),
		.count   (count),
		.full    (full)
	);

	convoy_control #(
		.RELEASE_GAP (RELEASE_GAP)
	) u_control (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.is_vector    (is_vector),
		.branch_taken (branch_taken),
		.full         (full),
		.drain_done   (drain_done),
		.exu_done     (exu_done),
		.instr_ready  (instr_ready),
		.wr_en        (wr_en),
		.clear        (clear),
		.drain_start  (drain_start),
		.freeze       (freeze)
	);

	vec_dispatch #(
		.SLOT_W (SLOT_W)
	) u_dispatch (
		.clk         (clk),
		.reset       (reset),
		.drain_start (drain_start),
		.count       (count),
		.rd_uop      (rd_uop),
		.rs1_data    (rs1_data),
		.rd_slot     (rd_slot),
		.rs1_sel     (rs1_sel),
		.exu_ready   (exu_ready),
		.exu_valid   (exu_valid),
		.exu_item    (exu_item),
		.drain_done  (drain_done)
	);

endmodule

`default_nettype wire

// File: bench/tb_vec_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vec_issue;
	import vec_issue_pkg::*;

	localparam int CONVOY_DEPTH = CONVOY_DEPTH_DEF;
	localparam int SLOT_W       = SLOT_W_DEF;
	localparam int RELEASE_GAP  = RELEASE_GAP_DEF;
	localparam int NUM_TESTS    = 5;
	localparam int DONE_DELAY   = 3;     // EXU latency, last transfer to exu_done

	logic        clk = 1'b0;
	logic        reset;
	logic        instr_valid;
	logic [31:0] instr;
	logic        instr_ready;
	logic        freeze;
	logic        branch_taken;
	logic [4:0]  rs1_sel;
	logic [31:0] rs1_data;
	logic        exu_valid;
	vec_issue_t  exu_item;
	logic        exu_ready;
	logic        exu_done;

	vec_issue_t  log_q[$];                 // Filled by the EXU model only
	vec_issue_t  exp_q[$];                 // Built from the decode rule
	int          log_rd       = 0;         // Next log entry to compare
	logic [31:0] lcg_state    = 32'd80238; // Field generator
	logic        ready_random = 1'b0;      // Random exu_ready when set
	int          stall_cycles = 0;
	int          errors       = 0;
	int          exu_errors   = 0;         // Counted by the EXU model
	int          failed_tests = 0;

	vec_issue_top #(
		.CONVOY_DEPTH (CONVOY_DEPTH),
		.SLOT_W       (SLOT_W),
		.RELEASE_GAP  (RELEASE_GAP)
	) UUT (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.instr_ready  (instr_ready),
		.freeze       (freeze),
		.branch_taken (branch_taken),
		.rs1_sel      (rs1_sel),
		.rs1_data     (rs1_data),
		.exu_valid    (exu_valid),
		.exu_item     (exu_item),
		.exu_ready    (exu_ready),
		.exu_done     (exu_done)
	);

	always #50 clk = ~clk;    // 100 ns period

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Scalar register file model
	function automatic logic [31:0] reg_value(input logic [4:0] sel);
		return 32'hA5C3_0000 ^ {27'd0, sel};
	endfunction

	assign rs1_data = reg_value(rs1_sel);    // Combinational read

	////////////////////////////////////////
	// Execution unit model
	////////////////////////////////////////
	initial begin : exu_model
		logic        tail;       // Last handshake may have closed the convoy
		logic        stalled;
		logic        pulse;
		logic        rdy;
		vec_issue_t  held;
		logic [31:0] rnd;
		int          done_cnt;
		tail      = 1'b0;
		stalled   = 1'b0;
		held      = '0;
		rnd       = 32'd80238;
		done_cnt  = 0;
		exu_ready = 1'b1;
		exu_done  = 1'b0;
		forever begin
			@(negedge clk);    // Values here are the ones the next edge samples
			if (stalled && (!exu_valid || exu_item !== held)) begin
				$display("Mismatch exu_item under back-pressure: got %h, held %h",
					exu_item, held);
				exu_errors++;
			end
			stalled = exu_valid && !exu_ready;
			held    = exu_item;
			if (stalled) stall_cycles++;
			pulse = 1'b0;
			if (done_cnt != 0) begin
				done_cnt--;
				pulse = (done_cnt == 0);
			end
			if (tail && !exu_valid) done_cnt = DONE_DELAY;    // Port idle after a transfer
			tail = exu_valid && exu_ready;
			if (tail) log_q.push_back(exu_item);
			rnd = lcg_step(rnd);
			rdy = ready_random ? rnd[16] : 1'b1;
			@(posedge clk);
			#1;
			exu_ready = rdy;
			exu_done  = pulse;
		end
	end

	initial begin : watchdog
		repeat (NUM_TESTS * 400) @(posedge clk);
		$display("Timeout, run not finished after %0d cycles", NUM_TESTS * 400);
		$display("Regression failed");
		$finish;
	end

	////////////////////////////////////////
	// Fetch side and checking helpers
	////////////////////////////////////////
	task automatic send_instr(input logic [31:0] word);
		int waited;
		waited      = 0;
		instr_valid = 1'b1;
		instr       = word;
		@(negedge clk);
		while (!instr_ready && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (!instr_ready) begin
			$display("Fetch handshake never completed for instruction %h", word);
			errors++;
		end
		@(posedge clk);    // Accepted here
		#1;
		instr_valid = 1'b0;
	endtask

	// Encodes one vector instruction and queues the item it should become
	task automatic issue_vec(input uop_kind_e kind, input src_sel_e src,
		input logic [31:0] f, input logic [2:0] slot);
		vec_issue_t want;
		logic [6:0] op;
		logic [2:0] f3;
		want = '0;
		op   = OP_VARITH;
		f3   = 3'b110;                  // Element width for memory forms
		case (kind)
			UOP_LOAD:  op = OP_VLOAD;
			UOP_STORE: op = OP_VSTORE;
			default: begin
				case (src)
					SRC_VV:  f3 = 3'b000;
					SRC_VX:  f3 = 3'b100;
					default: f3 = 3'b011;
				endcase
			end
		endcase
		want.uop.kind    = kind;
		want.uop.funct6  = f[31:26];
		want.uop.mask_en = ~f[25];
		want.uop.vs2     = f[24:20];
		want.uop.vs1_rs1 = f[19:15];
		want.uop.src_sel = (kind == UOP_ARITH) ? src : SRC_VX;    // Base address is scalar
		want.uop.vd      = f[11:7];
		want.rs1_value   = reg_value(f[19:15]);
		want.slot        = slot;
		exp_q.push_back(want);
		send_instr({f[31:15], f3, f[11:7], op});
	endtask

	task automatic issue_arith_convoy();
		src_sel_e form;
		for (int i = 0; i < CONVOY_DEPTH; i++) begin
			case (i % 3)
				0:       form = SRC_VV;
				1:       form = SRC_VX;
				default: form = SRC_VI;
			endcase
			lcg_state = lcg_step(lcg_state);
			issue_vec(UOP_ARITH, form, lcg_state, 3'(i));
		end
	endtask

	// Waits for exu_done, then measures the freeze tail
	task automatic wait_release();
		int waited;
		int gap;
		waited = 0;
		gap    = 0;
		do begin
			@(negedge clk);
			if (freeze && instr_ready) begin
				$display("Fetch offered while the scalar pipe is frozen");
				errors++;
			end
			waited++;
		end while (!exu_done && waited < 200);
		if (!exu_done) begin
			$display("exu_done never arrived after the drain");
			errors++;
		end
		@(negedge clk);    // Edge in between sampled exu_done
		while (freeze && gap < 50) begin
			@(negedge clk);
			gap++;
			if (freeze && instr_ready) begin
				$display("Fetch offered while the scalar pipe is frozen");
				errors++;
			end
		end
		if (gap != RELEASE_GAP + 1) begin
			$display("Mismatch freeze release gap: got %h, expected %h", gap, RELEASE_GAP + 1);
			errors++;
		end
		if (!instr_ready) begin
			$display("instr_ready still low when freeze fell");
			errors++;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic compare_log();
		vec_issue_t got;
		vec_issue_t want;
		int         seen;
		seen = log_q.size() - log_rd;
		if (seen != exp_q.size()) begin
			$display("Transfer count wrong, %0d seen and %0d expected", seen, exp_q.size());
			errors++;
		end
		while (log_rd < log_q.size() && exp_q.size() > 0) begin
			got  = log_q[log_rd];
			want = exp_q.pop_front();
			log_rd++;
			if (got.slot !== want.slot) begin
				$display("Mismatch exu_item.slot: got %h, expected %h", got.slot, want.slot);
				errors++;
			end
			if (got.uop !== want.uop) begin
				$display("Mismatch exu_item.uop at slot %0d: got %h, expected %h",
					want.slot, got.uop, want.uop);
				errors++;
			end
			// Scalar operand only matters for VX entries
			if (want.uop.src_sel == SRC_VX && got.rs1_value !== want.rs1_value) begin
				$display("Mismatch exu_item.rs1_value at slot %0d: got %h, expected %h",
					want.slot, got.rs1_value, want.rs1_value);
				errors++;
			end
		end
		log_rd = log_q.size();
		exp_q.delete();
	endtask

	task automatic report_test(input string name, input int start);
		if (errors == start) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d errors", name, errors - start);
			failed_tests++;
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////
	task automatic full_convoy();
		int start;
		start = errors;
		issue_arith_convoy();
		if (!freeze) begin
			$display("freeze not raised after the last entry of a full convoy");
			errors++;
		end
		wait_release();
		compare_log();
		report_test("full_convoy", start);
	endtask

	task automatic scalar_break();
		int start;
		start = errors;
		lcg_state = lcg_step(lcg_state);
		issue_vec(UOP_LOAD, SRC_VX, lcg_state, 3'd0);
		lcg_state = lcg_step(lcg_state);
		issue_vec(UOP_STORE, SRC_VX, lcg_state, 3'd1);
		lcg_state = lcg_step(lcg_state);
		issue_vec(UOP_LOAD, SRC_VX, lcg_state, 3'd2);
		send_instr(32'h00A0_8093);    // addi x1, x1, 10 closes the convoy
		if (!freeze) begin
			$display("freeze not raised after the scalar instruction");
			errors++;
		end
		instr_valid = 1'b1;           // Keep fetch offering during the drain
		wait_release();
		instr_valid = 1'b0;
		compare_log();
		report_test("scalar_break", start);
	endtask

	task automatic branch_flush();
		int start;
		start = errors;
		lcg_state = lcg_step(lcg_state);
		issue_vec(UOP_ARITH, SRC_VX, lcg_state, 3'd0);
		lcg_state = lcg_step(lcg_state);
		issue_vec(UOP_ARITH, SRC_VV, lcg_state, 3'd1);
		exp_q.delete();               // Both discarded by the branch
		branch_taken = 1'b1;
		@(posedge clk);
		#1;
		branch_taken = 1'b0;
		repeat (4) begin
			@(negedge clk);
			if (freeze || !instr_ready) begin
				$display("Unit not back in idle after the branch flush");
				errors++;
			end
		end
		if (log_q.size() != log_rd) begin
			$display("Flushed convoy reached the execution port");
			errors++;
		end
		@(posedge clk);
		#1;
		issue_arith_convoy();         // Must start again from slot 0
		wait_release();
		compare_log();
		report_test("branch_flush", start);
	endtask

	task automatic back_pressure();
		int start;
		int stalls_before;
		start         = errors + exu_errors;
		stalls_before = stall_cycles;
		ready_random  = 1'b1;
		issue_arith_convoy();
		wait_release();
		ready_random = 1'b0;
		compare_log();
		if (stall_cycles == stalls_before) begin
			$display("Random exu_ready produced no stall");
			errors++;
		end
		errors = errors + exu_errors;    // Hold violations seen by the model
		exu_errors = 0;
		report_test("back_pressure", start);
	endtask

	task automatic scalar_operand();
		int          start;
		logic [31:0] f;
		start = errors;
		for (int i = 0; i < 5; i++) begin
			lcg_state = lcg_step(lcg_state);
			f         = lcg_state;
			f[19:15]  = 5'(i * 7 + 3);    // rs1 spread over the register file
			issue_vec(UOP_ARITH, SRC_VX, f, 3'(i));
		end
		// OP-V with funct3 111 stays on the scalar side and closes the convoy
		send_instr({6'h03, 1'b0, 5'd0, 5'd5, 3'b111, 5'd6, OP_VARITH});
		wait_release();
		compare_log();
		report_test("scalar_operand", start);
	endtask

	////////////////////////////////////////
	// Sequence
	////////////////////////////////////////
	initial begin : main
		reset        = 1'b1;
		instr_valid  = 1'b0;
		instr        = '0;
		branch_taken = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		if (freeze || exu_valid || !instr_ready) begin
			$display("Outputs not at their reset values");
			errors++;
		end
		full_convoy();
		scalar_break();
		branch_flush();
		back_pressure();
		scalar_operand();
		errors = errors + exu_errors;
		$display("Tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
hw/vec_issue_pkg.sv
hw/vec_decoder.sv
hw/convoy_buffer.sv
hw/convoy_control.sv
hw/vec_dispatch.sv
hw/vec_issue_top.sv
bench/tb_vec_issue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_vec_issue -f compile.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "Regression failed" >> sim.log

cat sim.log

grep -q "Regression failed" sim.log && exit 1 || exit 0
